// ==== list.f ====
source/vsrc_pkg.sv
source/vsrc_pos_if.sv
source/vsrc_stream_if.sv
source/vsrc_frame_ctrl.sv
source/vsrc_throttle.sv
source/vsrc_pattern_gen.sv
source/vsrc_out_reg.sv
source/vsrc_top.sv
test/tb_vsrc.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the frame source testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_vsrc -o sim_tb_vsrc
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

out=$(./obj_dir/sim_tb_vsrc)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "NO ERRORS"; then
    exit 0
fi
exit 1

// ==== test/tb_vsrc.sv ====
// testbench for the frame source, 8x4 raster with 32-bit data
// a reference raster follows every output transfer and assertions compare against it

`timescale 1ns/100ps

module tb_vsrc;

    localparam int DATA_W = 32;
    localparam int X_NUM  = 8;
    localparam int Y_NUM  = 4;

    logic                          aclk;
    logic                          reg_aresetn;
    logic                          enable;
    vsrc_pkg::pattern_e            pattern_mode;
    logic [vsrc_pkg::RATE_W-1:0]   busy_rate = '0;
    logic [vsrc_pkg::COORD_W-1:0]  interval;
    logic                          m_tready = 1'b1;
    logic [DATA_W-1:0]             m_tdata;
    logic                          m_tuser;
    logic                          m_tlast;
    logic                          m_tvalid;

    integer  seed = 90;
    int      errors, tests, test_errs;
    string   test_name;
    bit      rand_ready, rand_busy, check_gap, expect_idle;

    // reference raster, advanced on output transfers
    int                  exp_x, exp_y, frame_cnt, idle_run;
    vsrc_pkg::pattern_e  frame_mode, cur_mode;
    logic [DATA_W-1:0]   exp_data;
    logic                xfer, exp_sof;

    vsrc_top #(.DATA_WIDTH(DATA_W), .X_NUM(X_NUM), .Y_NUM(Y_NUM)) i_dut (
        .aclk         (aclk),
        .reg_aresetn  (reg_aresetn),
        .enable       (enable),
        .pattern_mode (pattern_mode),
        .busy_rate    (busy_rate),
        .interval     (interval),
        .m_tready     (m_tready),
        .m_tdata      (m_tdata),
        .m_tuser      (m_tuser),
        .m_tlast      (m_tlast),
        .m_tvalid     (m_tvalid)
    );

    initial begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;
    end

    // pixel value straight from the pattern definitions
    function automatic logic [DATA_W-1:0] pixel_value(vsrc_pkg::pattern_e mode,
                                                      int x, int y, int f);
        logic [7:0] bar;
        bar = 8'(((x * 8) / X_NUM) * 32);
        case (mode)
            vsrc_pkg::PAT_XY:    pixel_value = {16'(y), 16'(x)};
            vsrc_pkg::PAT_BARS:  pixel_value = {4{bar}};
            vsrc_pkg::PAT_FRAME: pixel_value = {4{8'(f)}};
            default:             pixel_value = DATA_W'(y * X_NUM + x);
        endcase
    endfunction

    assign xfer     = m_tvalid && m_tready;
    assign exp_sof  = (exp_x == 0) && (exp_y == 0);
    assign cur_mode = exp_sof ? pattern_mode : frame_mode;
    assign exp_data = pixel_value(cur_mode, exp_x, exp_y, frame_cnt);

    always @(posedge aclk) begin
        if (!reg_aresetn) begin
            exp_x      <= 0;
            exp_y      <= 0;
            frame_cnt  <= 0;
            idle_run   <= 0;
            frame_mode <= vsrc_pkg::PAT_INDEX;
        end else begin
            idle_run <= m_tvalid ? 0 : idle_run + 1;
            if (xfer) begin
                if (exp_sof) begin
                    frame_mode <= pattern_mode;
                end
                if (exp_x == X_NUM - 1) begin
                    exp_x <= 0;
                    exp_y <= (exp_y == Y_NUM - 1) ? 0 : exp_y + 1;
                    if (exp_y == Y_NUM - 1) begin
                        frame_cnt <= frame_cnt + 1;
                    end
                end else begin
                    exp_x <= exp_x + 1;
                end
            end
        end
    end

    // random ready and busy rate, driven just after the edge
    always @(posedge aclk) begin
        #1;
        m_tready  <= rand_ready ? (($random(seed) & 3) != 0) : 1'b1;
        busy_rate <= rand_busy ? 7'($random(seed) & 63) : 7'd0;
    end

    task automatic report_value(string what, logic [DATA_W-1:0] exp, logic [DATA_W-1:0] act);
        $display("Error in test %s: %s expected %h, actual %h", test_name, what, exp, act);
        errors++;
    endtask

    task automatic report_fault(string what);
        $display("Test %s failed: %s", test_name, what);
        errors++;
    endtask

    // ------------------------------------------------------------
    // checks
    // ------------------------------------------------------------

    a_data: assert property (@(posedge aclk) disable iff (!reg_aresetn)
        xfer |-> m_tdata == exp_data)
        else report_value("tdata", $sampled(exp_data), $sampled(m_tdata));
    a_user: assert property (@(posedge aclk) disable iff (!reg_aresetn)
        xfer |-> m_tuser == exp_sof)
        else report_value("tuser", DATA_W'($sampled(exp_sof)), DATA_W'($sampled(m_tuser)));
    a_last: assert property (@(posedge aclk) disable iff (!reg_aresetn)
        xfer |-> m_tlast == (exp_x == X_NUM - 1))
        else report_value("tlast", DATA_W'($sampled(exp_x) == X_NUM - 1),
                          DATA_W'($sampled(m_tlast)));
    a_hold: assert property (@(posedge aclk) disable iff (!reg_aresetn)
        (m_tvalid && !m_tready) |=> m_tvalid && $stable(m_tdata) && $stable(m_tuser)
            && $stable(m_tlast))
        else report_fault("stalled beat changed before its transfer");
    a_gap: assert property (@(posedge aclk) disable iff (!reg_aresetn)
        (xfer && exp_sof && check_gap) |-> idle_run >= int'(interval))
        else report_value("gap cycles", DATA_W'($sampled(interval)), DATA_W'($sampled(idle_run)));
    a_idle: assert property (@(posedge aclk) disable iff (!reg_aresetn)
        expect_idle |-> !m_tvalid)
        else report_fault("m_tvalid went high while the output should be idle");

    // ------------------------------------------------------------
    // sequencing
    // ------------------------------------------------------------

    task automatic start_test(string name);
        test_name = name;
        test_errs = errors;
    endtask

    task automatic finish_test();
        tests++;
        $display("test %s finished, %0d errors", test_name, errors - test_errs);
    endtask

    task automatic wait_frames(int n);
        int target;
        int cycles;
        target = frame_cnt + n;
        cycles = 0;
        while (frame_cnt < target && cycles < n * X_NUM * Y_NUM * 20 + 200) begin
            @(posedge aclk);
            #1;
            cycles++;
        end
        if (frame_cnt < target) begin
            report_fault("timed out waiting for frames to complete");
        end
    endtask

    task automatic wait_mid_frame();
        int cycles;
        cycles = 0;
        while (exp_y != Y_NUM / 2 && cycles < X_NUM * Y_NUM * 20 + 200) begin
            @(posedge aclk);
            #1;
            cycles++;
        end
        if (exp_y != Y_NUM / 2) begin
            report_fault("timed out waiting for the middle of a frame");
        end
    endtask

    initial begin
        reg_aresetn  = 1'b0;
        enable       = 1'b0;
        pattern_mode = vsrc_pkg::PAT_INDEX;
        interval     = '0;
        expect_idle  = 1'b1;
        repeat (3) @(posedge aclk);
        #1;
        reg_aresetn = 1'b1;

        start_test("reset_idle");
        repeat (12) @(posedge aclk);
        #1;
        expect_idle = 1'b0;
        enable      = 1'b1;
        finish_test();

        start_test("index");
        wait_frames(2);
        finish_test();

        start_test("flags_random");
        rand_ready = 1'b1;
        rand_busy  = 1'b1;
        wait_frames(3);
        finish_test();

        start_test("hold_stalled");
        wait_frames(2);
        finish_test();

        start_test("frame_gap");
        rand_ready = 1'b0;
        interval   = 16'd5;
        wait_frames(1);
        check_gap = 1'b1;
        wait_frames(2);
        check_gap = 1'b0;
        interval  = '0;
        finish_test();

        start_test("pattern_switch");
        rand_ready = 1'b1;
        for (int m = 1; m < 4; m++) begin
            wait_mid_frame();
            pattern_mode = vsrc_pkg::pattern_e'(m);
            wait_frames(2);
        end
        finish_test();

        start_test("enable_drop");
        wait_mid_frame();
        enable = 1'b0;
        wait_frames(1);
        expect_idle = 1'b1;
        repeat (20) @(posedge aclk);
        #1;
        finish_test();

        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== source/vsrc_top.sv ====
// video frame source, X_NUM x Y_NUM raster on an AXI4-Stream style output
// DATA_WIDTH must be a multiple of 16; first beat appears one cycle after a position transfer

`timescale 1ns/100ps

module vsrc_top #(
    parameter int DATA_WIDTH = 32,
    parameter int X_NUM      = 640,
    parameter int Y_NUM      = 480
) (
    input  logic                          aclk,
    input  logic                          reg_aresetn,
    input  logic                          enable,
    input  vsrc_pkg::pattern_e            pattern_mode,
    input  logic [vsrc_pkg::RATE_W-1:0]   busy_rate,
    input  logic [vsrc_pkg::COORD_W-1:0]  interval,
    input  logic                          m_tready,
    output logic [DATA_WIDTH-1:0]         m_tdata,
    output logic                          m_tuser,
    output logic                          m_tlast,
    output logic                          m_tvalid
);

    logic  busy;

    vsrc_pos_if pos_if ();
    vsrc_stream_if #(.DATA_WIDTH(DATA_WIDTH)) strm_if ();

    // ------------------------------------------------------------
    // control
    // ------------------------------------------------------------

    vsrc_throttle i_throttle (
        .aclk        (aclk),
        .reg_aresetn (reg_aresetn),
        .busy_rate   (busy_rate),
        .busy        (busy)
    );

    vsrc_frame_ctrl #(.X_NUM(X_NUM), .Y_NUM(Y_NUM)) i_frame_ctrl (
        .aclk        (aclk),
        .reg_aresetn (reg_aresetn),
        .enable      (enable),
        .interval    (interval),
        .busy        (busy),
        .pos         (pos_if.source)
    );

    // ------------------------------------------------------------
    // datapath
    // ------------------------------------------------------------

    vsrc_pattern_gen #(.DATA_WIDTH(DATA_WIDTH), .X_NUM(X_NUM)) i_pattern_gen (
        .aclk         (aclk),
        .reg_aresetn  (reg_aresetn),
        .pattern_mode (pattern_mode),
        .pos          (pos_if.sink),
        .strm         (strm_if.source)
    );

    vsrc_out_reg #(.DATA_WIDTH(DATA_WIDTH)) i_out_reg (
        .aclk        (aclk),
        .reg_aresetn (reg_aresetn),
        .m_tready    (m_tready),
        .strm        (strm_if.sink),
        .m_tdata     (m_tdata),
        .m_tuser     (m_tuser),
        .m_tlast     (m_tlast),
        .m_tvalid    (m_tvalid)
    );

endmodule

// ==== source/vsrc_out_reg.sv ====
// full-rate output register slice
// one beat per cycle with m_tready high, holds the beat while m_tready is low

`timescale 1ns/100ps

module vsrc_out_reg #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                   aclk,
    input  logic                   reg_aresetn,
    input  logic                   m_tready,
    vsrc_stream_if.sink            strm,
    output logic [DATA_WIDTH-1:0]  m_tdata,
    output logic                   m_tuser,
    output logic                   m_tlast,
    output logic                   m_tvalid
);

    logic  load;

    // take a new beat when empty or when the current one leaves
    assign strm.tready = !m_tvalid || m_tready;
    assign load        = strm.tvalid && strm.tready;

    // ------------------------------------------------------------
    // valid flag
    // ------------------------------------------------------------

    always_ff @(posedge aclk) begin
        if (!reg_aresetn) begin
            m_tvalid <= 1'b0;
        end else if (strm.tready) begin
            m_tvalid <= strm.tvalid;
        end
    end

    // ------------------------------------------------------------
    // payload
    // ------------------------------------------------------------

    always_ff @(posedge aclk) begin
        if (load) begin
            m_tdata <= strm.tdata;
            m_tuser <= strm.tuser;
            m_tlast <= strm.tlast;
        end
    end

    // a stalled beat stays put until taken
    a_hold_stalled: assert property (
        @(posedge aclk) disable iff (!reg_aresetn)
        (m_tvalid && !m_tready) |=>
            m_tvalid && $stable(m_tdata) && $stable(m_tuser) && $stable(m_tlast)
    );

endmodule

// ==== source/vsrc_pattern_gen.sv ====
// combinational pixel pattern from the current position
// pattern_mode is taken on the first pixel of each frame and held for that frame

`timescale 1ns/100ps

module vsrc_pattern_gen #(
    parameter int DATA_WIDTH = 32,
    parameter int X_NUM      = 640
) (
    input  logic                aclk,
    input  logic                reg_aresetn,
    input  vsrc_pkg::pattern_e  pattern_mode,
    vsrc_pos_if.sink            pos,
    vsrc_stream_if.source       strm
);

    localparam int HALF  = DATA_WIDTH / 2;
    localparam int BYTES = DATA_WIDTH / 8;
    localparam int IDX_W = 2 * vsrc_pkg::COORD_W;
    localparam int BAR_W = vsrc_pkg::COORD_W + 3;

    localparam logic [IDX_W-1:0] X_WIDE = IDX_W'(X_NUM);
    localparam logic [BAR_W-1:0] X_BAR  = BAR_W'(X_NUM);

    vsrc_pkg::pattern_e  mode_q;
    vsrc_pkg::pattern_e  mode;
    logic [IDX_W-1:0]    pix_index;
    logic [BAR_W-1:0]    x_times8;
    logic [BAR_W-1:0]    bar_idx;
    logic [7:0]          bar_byte;

    // mode held for the frame, the sof pixel already sees the new one
    always_ff @(posedge aclk) begin
        if (!reg_aresetn) begin
            mode_q <= vsrc_pkg::PAT_INDEX;
        end else if (pos.valid && pos.ready && pos.sof) begin
            mode_q <= pattern_mode;
        end
    end

    assign mode = (pos.valid && pos.sof) ? pattern_mode : mode_q;

    // ------------------------------------------------------------
    // pattern arithmetic
    // ------------------------------------------------------------

    assign pix_index = pos.y * X_WIDE + pos.x;

    // bar number 0..7 across the line
    assign x_times8 = {pos.x, 3'b000};
    assign bar_idx  = x_times8 / X_BAR;
    assign bar_byte = {bar_idx[2:0], 5'b00000};

    always_comb begin
        case (mode)
            vsrc_pkg::PAT_INDEX: strm.tdata = DATA_WIDTH'(pix_index);
            vsrc_pkg::PAT_XY:    strm.tdata = {HALF'(pos.y), HALF'(pos.x)};
            vsrc_pkg::PAT_BARS:  strm.tdata = {BYTES{bar_byte}};
            vsrc_pkg::PAT_FRAME: strm.tdata = {BYTES{pos.frame_num[7:0]}};
            default:             strm.tdata = DATA_WIDTH'(pix_index);
        endcase
    end

    // handshake and sideband pass straight through
    assign strm.tvalid = pos.valid;
    assign strm.tuser  = pos.sof;
    assign strm.tlast  = pos.eol;
    assign pos.ready   = strm.tready;

endmodule

// ==== source/vsrc_throttle.sv ====
// random stall source from a 7-bit maximal LFSR
// busy_rate is out of 128, 0 never stalls

`timescale 1ns/100ps

module vsrc_throttle (
    input  logic                         aclk,
    input  logic                         reg_aresetn,
    input  logic [vsrc_pkg::RATE_W-1:0]  busy_rate,
    output logic                         busy
);

    // any nonzero value works as seed
    localparam logic [vsrc_pkg::RATE_W-1:0] SEED = 7'h5a;

    logic [vsrc_pkg::RATE_W-1:0]  lfsr;
    logic                         feedback;

    // taps for x^7 + x^6 + 1, period 127
    assign feedback = lfsr[6] ^ lfsr[5];

    always_ff @(posedge aclk) begin
        if (!reg_aresetn) begin
            lfsr <= SEED;
        end else begin
            lfsr <= {lfsr[5:0], feedback};
        end
    end

    // lfsr spans 1..127 so busy_rate of 0 gives no stalls
    assign busy = (lfsr < busy_rate);

    // the all-zero state would lock up the sequence
    a_lfsr_nonzero: assert property (
        @(posedge aclk) disable iff (!reg_aresetn)
        lfsr != '0
    );

endmodule

// ==== source/vsrc_frame_ctrl.sv ====
// raster scan controller, emits one position per handshake
// enable is sampled only at frame boundaries; interval counts idle cycles after a frame

`timescale 1ns/100ps

module vsrc_frame_ctrl #(
    parameter int X_NUM = 640,
    parameter int Y_NUM = 480
) (
    input  logic                          aclk,
    input  logic                          reg_aresetn,
    input  logic                          enable,
    input  logic [vsrc_pkg::COORD_W-1:0]  interval,
    input  logic                          busy,
    vsrc_pos_if.source                    pos
);

    localparam logic [vsrc_pkg::COORD_W-1:0] X_LAST = vsrc_pkg::COORD_W'(X_NUM - 1);
    localparam logic [vsrc_pkg::COORD_W-1:0] Y_LAST = vsrc_pkg::COORD_W'(Y_NUM - 1);

    vsrc_pkg::ctrl_state_e          state;
    logic [vsrc_pkg::COORD_W-1:0]   x_cnt;
    logic [vsrc_pkg::COORD_W-1:0]   y_cnt;
    logic [vsrc_pkg::FRAME_W-1:0]   frame_cnt;
    logic [vsrc_pkg::COORD_W-1:0]   gap_cnt;
    // a beat was offered last cycle and not taken
    logic                           pend;
    logic                           xfer;

    // ------------------------------------------------------------
    // position outputs
    // ------------------------------------------------------------

    // busy may only stall before a beat is offered, never while it waits
    assign pos.valid     = (state == vsrc_pkg::ST_ACTIVE) && (!busy || pend);
    assign pos.x         = x_cnt;
    assign pos.y         = y_cnt;
    assign pos.frame_num = frame_cnt;
    assign pos.sof       = (x_cnt == '0) && (y_cnt == '0);
    assign pos.eol       = (x_cnt == X_LAST);

    assign xfer = pos.valid && pos.ready;

    // ------------------------------------------------------------
    // raster state machine and counters
    // ------------------------------------------------------------

    always_ff @(posedge aclk) begin
        if (!reg_aresetn) begin
            state     <= vsrc_pkg::ST_IDLE;
            x_cnt     <= '0;
            y_cnt     <= '0;
            frame_cnt <= '0;
            gap_cnt   <= '0;
            pend      <= 1'b0;
        end else begin
            pend <= pos.valid && !pos.ready;

            case (state)
                vsrc_pkg::ST_IDLE: begin
                    if (enable) begin
                        state <= vsrc_pkg::ST_ACTIVE;
                    end
                end

                vsrc_pkg::ST_ACTIVE: begin
                    if (xfer) begin
                        if (x_cnt == X_LAST) begin
                            x_cnt <= '0;
                            if (y_cnt == Y_LAST) begin
                                // frame done
                                y_cnt     <= '0;
                                frame_cnt <= frame_cnt + 1'b1;
                                if (interval != '0) begin
                                    state   <= vsrc_pkg::ST_GAP;
                                    gap_cnt <= interval - 1'b1;
                                end else if (!enable) begin
                                    state <= vsrc_pkg::ST_IDLE;
                                end
                            end else begin
                                y_cnt <= y_cnt + 1'b1;
                            end
                        end else begin
                            x_cnt <= x_cnt + 1'b1;
                        end
                    end
                end

                vsrc_pkg::ST_GAP: begin
                    if (gap_cnt == '0) begin
                        if (enable) begin
                            state <= vsrc_pkg::ST_ACTIVE;
                        end else begin
                            state <= vsrc_pkg::ST_IDLE;
                        end
                    end else begin
                        gap_cnt <= gap_cnt - 1'b1;
                    end
                end

                default: begin
                    state <= vsrc_pkg::ST_IDLE;
                end
            endcase
        end
    end

    // ------------------------------------------------------------
    // checks
    // ------------------------------------------------------------

    // offered position always lies inside the raster
    a_pos_in_range: assert property (
        @(posedge aclk) disable iff (!reg_aresetn)
        pos.valid |-> (x_cnt < X_NUM) && (y_cnt < Y_NUM)
    );

endmodule

// ==== source/vsrc_stream_if.sv ====
// internal stream beat link, AXI4-Stream style
// tuser marks start of frame, tlast marks end of line

`timescale 1ns/100ps

interface vsrc_stream_if #(
    parameter int DATA_WIDTH = 32
);

    logic [DATA_WIDTH-1:0]  tdata;
    logic                   tuser;
    logic                   tlast;
    logic                   tvalid;
    logic                   tready;

    modport source (
        output tdata, tuser, tlast, tvalid,
        input  tready
    );

    modport sink (
        input  tdata, tuser, tlast, tvalid,
        output tready
    );

endinterface

// ==== source/vsrc_pos_if.sv ====
// pixel position link, valid/ready handshake
// x, y, frame_num, sof and eol hold steady while valid waits for ready

`timescale 1ns/100ps

interface vsrc_pos_if;

    logic                          valid;
    logic                          ready;
    logic [vsrc_pkg::COORD_W-1:0]  x;
    logic [vsrc_pkg::COORD_W-1:0]  y;
    logic [vsrc_pkg::FRAME_W-1:0]  frame_num;
    // first pixel of frame
    logic                          sof;
    // last pixel of line
    logic                          eol;

    modport source (
        output valid, x, y, frame_num, sof, eol,
        input  ready
    );

    modport sink (
        input  valid, x, y, frame_num, sof, eol,
        output ready
    );

endinterface

// ==== source/vsrc_pkg.sv ====
// shared types and widths for the frame source
// coordinate and frame counters wrap silently at their widths

package vsrc_pkg;

    // ------------------------------------------------------------
    // widths
    // ------------------------------------------------------------

    // x and y coordinate width, also used for the gap interval
    localparam int COORD_W = 16;

    // frame number width
    localparam int FRAME_W = 16;

    // busy threshold and LFSR width, busy rate is out of 128
    localparam int RATE_W  = 7;

    // ------------------------------------------------------------
    // enums
    // ------------------------------------------------------------

    // pixel pattern selection
    typedef enum logic [1:0] {
        PAT_INDEX = 2'd0,   // raster index y*X_NUM + x
        PAT_XY    = 2'd1,   // y in upper half, x in lower half
        PAT_BARS  = 2'd2,   // eight vertical bars
        PAT_FRAME = 2'd3    // low byte of frame number in every byte
    } pattern_e;

    // raster controller states
    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_ACTIVE = 2'd1,
        ST_GAP    = 2'd2
    } ctrl_state_e;

endpackage
